// File: src.f
source/div_pkg.sv
source/div_ctrl.sv
source/div_operand_cache.sv
source/div_normalize.sv
source/div_goldschmidt.sv
source/div_result.sv
source/div_top.sv
bench/div_checker.sv
bench/div_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       ?= ./$(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/div_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_tb;
    import div_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam logic [31:0] SEED         = 32'hc3c0;
    localparam int          NUM_RANDOM   = 300;
    // directed operations, rounded up
    localparam int          NUM_DIRECTED = 100;
    // about 8 cycles an operation, margin for the ack hold-offs
    localparam int          MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * 8 + NUM_RANDOM * 2 + 200;

    logic              clk;
    logic              rst_n;
    logic [OP_LN-1:0]  op1;
    logic [OP_LN-1:0]  op2;
    div_fn_t           fn;
    logic              start;
    logic              ack;
    logic [OP_LN-1:0]  result;
    logic              done;
    logic [31:0]       lcg_state;
    logic [OP_LN-1:0]  word_a;
    logic [OP_LN-1:0]  word_b;
    logic [OP_LN-1:0]  last_a;
    logic [OP_LN-1:0]  last_b;
    // done is high and not yet acked
    logic              result_open;
    int                op_count;
    int                cycles = 0;
    int                error_count;
    int                check_count;

    div_top u_div_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .op1    (op1),
        .op2    (op2),
        .fn     (fn),
        .start  (start),
        .ack    (ack),
        .result (result),
        .done   (done)
    );

    div_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .op1         (op1),
        .op2         (op2),
        .fn          (fn),
        .start       (start),
        .ack         (ack),
        .result      (result),
        .done        (done),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test still running after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_word(output logic [31:0] w);
        lcg_state = lcg_next(lcg_state);
        w = lcg_state;
    endtask

    task automatic wait_done;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one operation, hold is the number of cycles ack stays low after done
    task automatic run_op(input logic [OP_LN-1:0] a, input logic [OP_LN-1:0] b,
                          input div_fn_t f, input int hold, input bit leave_open);
        @(posedge clk);
        #1;
        op1   = a;
        op2   = b;
        fn    = f;
        start = 1'b1;
        // an open result is acked in the same cycle
        ack   = result_open;
        op_count = op_count + 1;
        @(posedge clk);
        #1;
        start = 1'b0;
        ack   = 1'b0;
        // operands only matter in the start cycle
        rand_word(op1);
        rand_word(op2);
        wait_done();
        repeat (hold) begin
            // start is ignored while the result waits
            rand_word(op1);
            rand_word(op2);
            start = 1'b1;
            @(posedge clk);
            #1;
        end
        start = 1'b0;
        if (leave_open) begin
            result_open = 1'b1;
        end else begin
            ack = 1'b1;
            @(posedge clk);
            #1;
            ack = 1'b0;
            result_open = 1'b0;
        end
    endtask

    task automatic random_op;
        logic [OP_LN-1:0] a;
        logic [OP_LN-1:0] b;
        logic [31:0]      r;
        int               hold;
        rand_word(a);
        rand_word(b);
        rand_word(r);
        if (r[18:16] == 3'd0) begin
            // same magnitudes again for the repeat path
            a = last_a;
            b = r[15] ? -last_b : last_b;
        end else begin
            b = b >> r[31:27];
            if (r[26:25] == 2'd0) begin
                b = b & 32'hff;
            end
        end
        hold   = r[22] ? int'(r[21:20]) : 0;
        last_a = a;
        last_b = b;
        run_op(a, b, div_fn_t'(r[24:23]), hold, r[19]);
    endtask

    initial begin
        rst_n       = 1'b0;
        op1         = '0;
        op2         = '0;
        fn          = DIV;
        start       = 1'b0;
        ack         = 1'b0;
        result_open = 1'b0;
        op_count    = 0;
        lcg_state   = SEED;
        last_a      = OP_LN'(1);
        last_b      = OP_LN'(1);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // zero divisor and signed overflow
        run_op(32'h1234_5678, '0, DIV, 0, 1'b0);
        run_op(32'hdead_beef, '0, DIVU, 0, 1'b0);
        run_op(32'hdead_beef, '0, REM, 0, 1'b0);
        run_op(32'h0000_0007, '0, REMU, 2, 1'b1);
        run_op(32'h8000_0000, 32'hffff_ffff, DIV, 0, 1'b1);
        run_op(32'h8000_0000, 32'hffff_ffff, REM, 0, 1'b0);
        // unsigned this is an ordinary division, REMU then repeats it
        run_op(32'h8000_0000, 32'hffff_ffff, DIVU, 0, 1'b0);
        run_op(32'h8000_0000, 32'hffff_ffff, REMU, 0, 1'b0);

        // same magnitudes with another function or other signs
        run_op(-32'd100, 32'd7, DIV, 0, 1'b0);
        run_op(-32'd100, 32'd7, REM, 0, 1'b0);
        run_op(32'd100, -32'd7, DIV, 0, 1'b0);
        run_op(32'd100, -32'd7, REM, 0, 1'b1);
        run_op(-32'd100, -32'd7, REM, 0, 1'b0);
        run_op(32'd100, 32'd7, DIVU, 0, 1'b0);
        run_op(32'd100, 32'd7, DIV, 0, 1'b0);
        run_op(32'd100, 32'd7, REMU, 0, 1'b0);

        // back-pressure, then starts that carry the ack
        rand_word(word_a);
        rand_word(word_b);
        run_op(word_a, word_b >> 4, DIVU, 5, 1'b1);
        run_op(word_a, word_b >> 4, REMU, 3, 1'b1);
        run_op(word_b, word_a >> 8, DIV, 4, 1'b0);

        // every power of two is a half case for the normaliser
        for (int k = 0; k < OP_LN; k++) begin
            rand_word(word_a);
            run_op(word_a, 32'd1 << k, div_fn_t'(2'(k)), 0, 1'b0);
            run_op(word_a, -(32'd1 << k), (k % 2 == 0) ? DIV : REM, 0, 1'b0);
        end
        for (int f = 0; f < 4; f++) begin
            rand_word(word_a);
            run_op(word_a, 32'd1, div_fn_t'(2'(f)), 0, 1'b0);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_op();
        end

        if (result_open) begin
            ack = 1'b1;
            @(posedge clk);
            #1;
            ack = 1'b0;
            result_open = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        $display("operations: %0d, checked: %0d, errors: %0d", op_count, check_count,
                 error_count);
        if ((error_count == 0) && (check_count == op_count)) begin
            $display("SIMULATION PASSED");
        end else begin
            if (check_count != op_count) begin
                $display("not every started operation came back with a result");
            end
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/div_checker.sv
`timescale 1ns/1ps
`default_nettype none

module div_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [div_pkg::OP_LN-1:0]   op1,
    input  logic [div_pkg::OP_LN-1:0]   op2,
    input  div_pkg::div_fn_t            fn,
    input  logic                        start,
    input  logic                        ack,
    input  logic [div_pkg::OP_LN-1:0]   result,
    input  logic                        done,
    output int                          error_count,
    output int                          check_count
);
    import div_pkg::*;

    localparam logic [OP_LN-1:0] MIN_NEG = {1'b1, {(OP_LN-1){1'b0}}};

    logic              pending;
    logic              holding;
    logic              in_reset;
    logic [OP_LN-1:0]  expected;
    logic [OP_LN-1:0]  held;
    logic [OP_LN-1:0]  exp_op1;
    logic [OP_LN-1:0]  exp_op2;
    div_fn_t           exp_fn;
    int                cycle;
    int                start_cycle;
    int                exp_latency;
    // last iterated division, a repeat of it comes back in one cycle
    logic [OP_LN-1:0]  last_abs1;
    logic [OP_LN-1:0]  last_abs2;
    logic              last_signs;
    logic              is_signed;
    logic              neg1;
    logic              neg2;
    logic [OP_LN-1:0]  abs1;
    logic [OP_LN-1:0]  abs2;

    // RISC-V M rules, truncating division and remainder signed like the dividend
    function automatic logic [OP_LN-1:0] ref_result(input logic [OP_LN-1:0] a,
                                                    input logic [OP_LN-1:0] b,
                                                    input div_fn_t f);
        logic [OP_LN-1:0] r;
        logic             ovfl;
        ovfl = (a == MIN_NEG) && (b == '1);
        case (f)
            DIV: begin
                if (b == '0) r = '1;
                else if (ovfl) r = a;
                else r = $signed(a) / $signed(b);
            end
            DIVU: begin
                if (b == '0) r = '1;
                else r = a / b;
            end
            REM: begin
                if (b == '0) r = a;
                else if (ovfl) r = '0;
                else r = $signed(a) % $signed(b);
            end
            default: begin
                if (b == '0) r = a;
                else r = a % b;
            end
        endcase
        return r;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            pending     = 1'b0;
            holding     = 1'b0;
            in_reset    = 1'b1;
            cycle       = 0;
            error_count = 0;
            check_count = 0;
            last_abs1   = OP_LN'(1);
            last_abs2   = OP_LN'(1);
            last_signs  = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (in_reset && (done !== 1'b0)) begin
                $display("done was not low after reset at %0d ns", $time);
                error_count = error_count + 1;
            end
            in_reset = 1'b0;

            if (pending && (done === 1'b1)) begin
                // a fresh completion
                check_count = check_count + 1;
                if (result !== expected) begin
                    $display("** Error at %0d ns: %s %h, %h gave %h, expected %h", $time,
                             exp_fn.name(), exp_op1, exp_op2, result, expected);
                    error_count = error_count + 1;
                end
                if ((cycle - start_cycle) != exp_latency) begin
                    $display("** Error at %0d ns: %s %h, %h done after %0d cycles, expected %0d",
                             $time, exp_fn.name(), exp_op1, exp_op2, cycle - start_cycle,
                             exp_latency);
                    error_count = error_count + 1;
                end
                pending = 1'b0;
                holding = 1'b1;
                held    = result;
            end else if (done === 1'b1) begin
                if (!holding) begin
                    $display("done went high at %0d ns with no operation started", $time);
                    error_count = error_count + 1;
                end else if (result !== held) begin
                    $display("** Error at %0d ns: result moved from %h to %h before ack",
                             $time, held, result);
                    error_count = error_count + 1;
                end
            end else if (holding) begin
                $display("done fell at %0d ns before the result was acked", $time);
                error_count = error_count + 1;
                holding = 1'b0;
            end

            // result consumed
            if (done && ack) begin
                holding = 1'b0;
            end

            // a start only counts when the divider can take it
            if (start && !pending && (!done || ack)) begin
                exp_op1     = op1;
                exp_op2     = op2;
                exp_fn      = fn;
                expected    = ref_result(op1, op2, fn);
                start_cycle = cycle;
                is_signed   = (fn == DIV) || (fn == REM);
                neg1        = is_signed && op1[OP_LN-1];
                neg2        = is_signed && op2[OP_LN-1];
                abs1        = neg1 ? -op1 : op1;
                abs2        = neg2 ? -op2 : op2;
                if ((op2 == '0) || (is_signed && (op1 == MIN_NEG) && (op2 == '1))) begin
                    exp_latency = 1;
                end else if (((neg1 || neg2) == last_signs) && (abs1 == last_abs1) &&
                             (abs2 == last_abs2)) begin
                    exp_latency = 1;
                end else begin
                    // start cycle, four iterations, finish
                    exp_latency = 6;
                    last_abs1   = abs1;
                    last_abs2   = abs2;
                    last_signs  = neg1 || neg2;
                end
                pending = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/div_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // op1 is the dividend, op2 the divisor
    input  logic [div_pkg::OP_LN-1:0]   op1,
    input  logic [div_pkg::OP_LN-1:0]   op2,
    input  div_pkg::div_fn_t            fn,
    input  logic                        start,
    input  logic                        ack,
    output logic [div_pkg::OP_LN-1:0]   result,
    output logic                        done
);
    import div_pkg::*;

    // step pulses from the controller
    logic                  init;
    logic                  save;
    logic                  finish;
    logic                  skip;

    // operand side
    div_case_t             case_cur;
    div_fn_t               fn_cur;
    logic [OP_LN-1:0]      op1_abs;
    logic [OP_LN-1:0]      op2_abs;
    logic [OP_LN-1:0]      op1_abs_saved;
    logic [OP_LN-1:0]      op2_abs_saved;
    logic                  op1_neg_saved;
    logic                  sign_saved;
    logic                  op1_neg_cur;
    logic                  sign_cur;

    // iteration datapath
    logic [C_LN-1:0]       x_init;
    logic [OP_LN_LG+1:0]   shift_init;
    logic [C_LN-1:0]       num;
    logic [OP_LN_LG+1:0]   shift;

    div_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .ack    (ack),
        .skip   (skip),
        .done   (done),
        .init   (init),
        .save   (save),
        .finish (finish)
    );

    div_operand_cache u_cache (
        .clk           (clk),
        .rst_n         (rst_n),
        .op1           (op1),
        .op2           (op2),
        .fn            (fn),
        .init          (init),
        .case_cur      (case_cur),
        .skip          (skip),
        .fn_cur        (fn_cur),
        .op1_abs       (op1_abs),
        .op2_abs       (op2_abs),
        .op1_neg_saved (op1_neg_saved),
        .sign_saved    (sign_saved),
        .op1_neg_cur   (op1_neg_cur),
        .sign_cur      (sign_cur),
        .op1_abs_saved (op1_abs_saved),
        .op2_abs_saved (op2_abs_saved)
    );

    div_normalize u_norm (
        .op2_abs    (op2_abs),
        .x_init     (x_init),
        .shift_init (shift_init)
    );

    div_goldschmidt u_gold (
        .clk        (clk),
        .rst_n      (rst_n),
        .init       (init),
        .x_init     (x_init),
        .shift_init (shift_init),
        .op1_abs    (op1_abs),
        .num        (num),
        .shift      (shift)
    );

    div_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .init          (init),
        .save          (save),
        .finish        (finish),
        .case_cur      (case_cur),
        .fn_cur        (fn_cur),
        .num           (num),
        .shift         (shift),
        .op1           (op1),
        .op1_abs_saved (op1_abs_saved),
        .op2_abs_saved (op2_abs_saved),
        .op1_neg_saved (op1_neg_saved),
        .sign_saved    (sign_saved),
        .op1_neg_cur   (op1_neg_cur),
        .sign_cur      (sign_cur),
        .result        (result)
    );

endmodule

`default_nettype wire

// File: source/div_result.sv
`timescale 1ns/1ps
`default_nettype none

module div_result (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           init,
    input  logic                           save,
    input  logic                           finish,
    input  div_pkg::div_case_t             case_cur,
    input  div_pkg::div_fn_t               fn_cur,
    input  logic [div_pkg::C_LN-1:0]       num,
    input  logic [div_pkg::OP_LN_LG+1:0]   shift,
    input  logic [div_pkg::OP_LN-1:0]      op1,
    input  logic [div_pkg::OP_LN-1:0]      op1_abs_saved,
    input  logic [div_pkg::OP_LN-1:0]      op2_abs_saved,
    input  logic                           op1_neg_saved,
    input  logic                           sign_saved,
    input  logic                           op1_neg_cur,
    input  logic                           sign_cur,
    output logic [div_pkg::OP_LN-1:0]      result
);
    import div_pkg::*;

    logic [C_LN:0]       num_rnd;
    logic [C_LN:0]       num_eff;
    logic [OP_LN-1:0]    quo_est;
    logic [OP_LN-1:0]    rem_est;
    logic                fix;
    logic [OP_LN-1:0]    quo_abs;
    logic [OP_LN-1:0]    rem_abs;
    logic [OP_LN-1:0]    quo;
    logic [OP_LN-1:0]    rem;
    logic [OP_LN-1:0]    quo_abs_saved;
    logic [OP_LN-1:0]    rem_abs_saved;
    logic [OP_LN-1:0]    quo_sel;
    logic [OP_LN-1:0]    rem_sel;
    logic [OP_LN-1:0]    result_sel;

    // small bias below the integer bit, estimate stays at or under the quotient
    assign num_rnd = {1'b0, num} + (C_LN+1)'((1 << (XP_LN - 1)) - 1);
    assign num_eff = num_rnd >> shift;
    assign quo_est = num_eff[OP_LN-1:0];

    // no wrap, estimate times divisor never passes the dividend
    assign rem_est = op1_abs_saved - op2_abs_saved * quo_est;

    // estimate may be one short
    assign fix     = (rem_est >= op2_abs_saved);
    assign quo_abs = quo_est + OP_LN'(fix);
    assign rem_abs = fix ? rem_est - op2_abs_saved : rem_est;

    // quotient sign from both operands, remainder follows the dividend
    assign quo = sign_saved ? -quo_abs : quo_abs;
    assign rem = op1_neg_saved ? -rem_abs : rem_abs;

    // kept for repeats, reset pair is the answer to 1/1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quo_abs_saved <= OP_LN'(1);
            rem_abs_saved <= '0;
        end else if (save) begin
            quo_abs_saved <= quo_abs;
            rem_abs_saved <= rem_abs;
        end
    end

    always_comb begin
        case (case_cur)
            NORMAL: begin
                quo_sel = quo;
                rem_sel = rem;
            end
            DIV0: begin
                // all ones quotient, dividend as remainder
                quo_sel = '1;
                rem_sel = op1;
            end
            OVFL: begin
                quo_sel = op1;
                rem_sel = '0;
            end
            default: begin
                // repeat takes stored magnitudes with this operation's signs
                quo_sel = sign_cur ? -quo_abs_saved : quo_abs_saved;
                rem_sel = op1_neg_cur ? -rem_abs_saved : rem_abs_saved;
            end
        endcase
        result_sel = ((fn_cur == DIV) || (fn_cur == DIVU)) ? quo_sel : rem_sel;
    end

    // held until the next finish, stays put under back-pressure
    always_ff @(posedge clk) begin
        if (finish) begin
            result <= result_sel;
        end
    end

    // correction must leave a proper remainder, saved operands come from the cache
    a_rem_below_divisor: assert property (
        @(posedge clk) disable iff (!rst_n) save |-> (rem_abs < op2_abs_saved)
    ) else $error("remainder not below divisor after correction");

endmodule

`default_nettype wire

// File: source/div_goldschmidt.sv
`timescale 1ns/1ps
`default_nettype none

module div_goldschmidt (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           init,
    input  logic [div_pkg::C_LN-1:0]       x_init,
    input  logic [div_pkg::OP_LN_LG+1:0]   shift_init,
    input  logic [div_pkg::OP_LN-1:0]      op1_abs,
    output logic [div_pkg::C_LN-1:0]       num,
    output logic [div_pkg::OP_LN_LG+1:0]   shift
);
    import div_pkg::*;

    // x_reg holds x to the power 2^k, all fraction bits
    logic [C_LN-1:0]       x_reg;
    logic [C_LN-1:0]       x_cur;
    logic [C_LN-1:0]       x_next;
    logic [2*C_LN-1:0]     x_sq;
    logic [C_LN:0]         factor;
    logic [C_LN-1:0]       num_reg;
    logic [C_LN-1:0]       num_cur;
    logic [C_LN-1:0]       num_next;
    logic [2*C_LN:0]       num_prod;
    logic [OP_LN_LG+1:0]   shift_reg;
    logic [OP_LN_LG+1:0]   shift_cur;
    logic [OP_LN_LG+1:0]   shift_next;
    logic                  renorm;

    // start cycle loads straight from the operands
    assign x_cur     = init ? x_init : x_reg;
    assign num_cur   = init ? {op1_abs, {XP_LN{1'b0}}} : num_reg;
    assign shift_cur = init ? shift_init : shift_reg;

    assign x_sq   = (2*C_LN)'(x_cur) * (2*C_LN)'(x_cur);
    assign x_next = x_sq[2*C_LN-1:C_LN];

    // 1 + x with the binary point below the top bit
    assign factor   = {1'b1, x_cur};
    assign num_prod = (2*C_LN+1)'(num_cur) * (2*C_LN+1)'(factor);

    // numerator grew past C_LN bits, drop one more bit
    assign renorm   = num_prod[2*C_LN];
    assign num_next = renorm ? num_prod[2*C_LN:C_LN+1] : num_prod[2*C_LN-1:C_LN];

    // and owe one bit less at the final shift
    assign shift_next = renorm ? shift_cur - 1'b1 : shift_cur;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_reg     <= '0;
            num_reg   <= '0;
            shift_reg <= '0;
        end else begin
            x_reg     <= x_next;
            num_reg   <= num_next;
            shift_reg <= shift_next;
        end
    end

    assign num   = num_reg;
    assign shift = shift_reg;

endmodule

`default_nettype wire

// File: source/div_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module div_normalize (
    input  logic [div_pkg::OP_LN-1:0]      op2_abs,
    output logic [div_pkg::C_LN-1:0]       x_init,
    output logic [div_pkg::OP_LN_LG+1:0]   shift_init
);
    import div_pkg::*;

    logic [OP_LN_LG-1:0]  high_bit;
    logic [OP_LN-1:0]     aligned;
    logic [OP_LN-1:0]     one_minus_x;
    logic [OP_LN-1:0]     x;
    logic                 half_case;

    // highest set bit wins, a zero divisor leaves index 0
    always_comb begin
        high_bit = '0;
        for (int i = 0; i < OP_LN; i++) begin
            if (op2_abs[i]) begin
                high_bit = OP_LN_LG'(i);
            end
        end
    end

    // binary point sits above the msb, divisor reads as 0.1xxx
    assign aligned = op2_abs << (OP_LN_LG'(OP_LN - 1) - high_bit);

    // a power of two gives exactly 0.5, x would not be below one half
    assign half_case = (aligned == {1'b1, {(OP_LN-1){1'b0}}});

    // in that case take the divisor as 1.0 and shift one less
    assign one_minus_x = half_case ? '0 : aligned;
    // the integer one drops out above the binary point
    assign x = -one_minus_x;

    assign x_init = {x, {XP_LN{1'b0}}};

    // high bit plus one undoes the alignment, XP_LN drops the fraction
    assign shift_init = (OP_LN_LG+2)'(high_bit) + (OP_LN_LG+2)'(XP_LN + 1)
                      - (OP_LN_LG+2)'(half_case);

endmodule

`default_nettype wire

// File: source/div_operand_cache.sv
`timescale 1ns/1ps
`default_nettype none

module div_operand_cache (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [div_pkg::OP_LN-1:0]   op1,
    input  logic [div_pkg::OP_LN-1:0]   op2,
    input  div_pkg::div_fn_t            fn,
    input  logic                        init,
    output div_pkg::div_case_t          case_cur,
    output logic                        skip,
    output div_pkg::div_fn_t            fn_cur,
    output logic [div_pkg::OP_LN-1:0]   op1_abs,
    output logic [div_pkg::OP_LN-1:0]   op2_abs,
    output logic                        op1_neg_saved,
    output logic                        sign_saved,
    output logic                        op1_neg_cur,
    output logic                        sign_cur,
    output logic [div_pkg::OP_LN-1:0]   op1_abs_saved,
    output logic [div_pkg::OP_LN-1:0]   op2_abs_saved
);
    import div_pkg::*;

    logic        is_signed;
    logic        op1_neg;
    logic        op2_neg;
    logic        op2_neg_saved;
    logic        has_signs;
    logic        has_signs_saved;
    div_case_t   case_now;
    div_case_t   case_saved;
    div_fn_t     fn_saved;

    // only DIV and REM look at the sign bits
    assign is_signed = (fn == DIV) || (fn == REM);
    assign op1_neg   = is_signed & op1[OP_LN-1];
    assign op2_neg   = is_signed & op2[OP_LN-1];

    // most negative value maps onto itself, read as unsigned it is right
    assign op1_abs = op1_neg ? -op1 : op1;
    assign op2_abs = op2_neg ? -op2 : op2;

    // repeat check compares sign presence of the same kind on both sides
    assign has_signs       = op1_neg | op2_neg;
    assign has_signs_saved = op1_neg_saved | op2_neg_saved;

    always_comb begin
        if (op2 == '0) begin
            case_now = DIV0;
        end else if (is_signed && (op1 == {1'b1, {(OP_LN-1){1'b0}}}) && (op2 == '1)) begin
            case_now = OVFL;
        end else if ((has_signs == has_signs_saved) && (op1_abs == op1_abs_saved) &&
                     (op2_abs == op2_abs_saved)) begin
            case_now = CACHED;
        end else begin
            case_now = NORMAL;
        end
    end

    // function and class follow every accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fn_saved   <= DIV;
            case_saved <= NORMAL;
        end else if (init) begin
            fn_saved   <= fn;
            case_saved <= case_now;
        end
    end

    // operands only from iterated divisions, reset state matches 1/1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_neg_saved <= 1'b0;
            op2_neg_saved <= 1'b0;
            op1_abs_saved <= OP_LN'(1);
            op2_abs_saved <= OP_LN'(1);
        end else if (init && (case_now == NORMAL)) begin
            op1_neg_saved <= op1_neg;
            op2_neg_saved <= op2_neg;
            op1_abs_saved <= op1_abs;
            op2_abs_saved <= op2_abs;
        end
    end

    assign sign_saved = op1_neg_saved ^ op2_neg_saved;

    // start cycle sees the inputs, later cycles the stored operation
    assign case_cur    = init ? case_now : case_saved;
    assign fn_cur      = init ? fn : fn_saved;
    assign op1_neg_cur = init ? op1_neg : op1_neg_saved;
    assign sign_cur    = init ? (op1_neg ^ op2_neg) : sign_saved;

    assign skip = (case_cur != NORMAL);

endmodule

`default_nettype wire

// File: source/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic ack,
    input  logic skip,
    output logic done,
    output logic init,
    output logic save,
    output logic finish
);
    import div_pkg::*;

    div_state_t                        state;
    div_state_t                        state_next;
    logic [$clog2(NUM_ITER+1)-1:0]     count;
    logic [$clog2(NUM_ITER+1)-1:0]     count_next;
    logic                              done_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            done  <= done_next;
        end
    end

    always_comb begin
        state_next = state;
        count_next = count;
        done_next  = 1'b0;
        init       = 1'b0;
        save       = 1'b0;
        finish     = 1'b0;
        case (state)
            IDLE: begin
                // result still waiting for ack, start is not taken
                if (done && !ack) begin
                    done_next = 1'b1;
                end else if (start) begin
                    init = 1'b1;
                    if (skip) begin
                        // special classes resolve in the start cycle
                        finish    = 1'b1;
                        done_next = 1'b1;
                    end else begin
                        // first iteration already runs in the start cycle
                        state_next = ITERATE;
                        count_next = ($bits(count))'(1);
                    end
                end
            end
            ITERATE: begin
                count_next = count + 1'b1;
                if (count == ($bits(count))'(NUM_ITER - 1)) begin
                    state_next = FINISH;
                end
            end
            FINISH: begin
                // numerator is final here, result and saved values load
                save       = 1'b1;
                finish     = 1'b1;
                done_next  = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // done only ever comes out of IDLE or FINISH
    a_no_done_iterating: assert property (
        @(posedge clk) disable iff (!rst_n) (state == ITERATE) |-> !done
    ) else $error("done high while iterating");

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n) count <= ($bits(count))'(NUM_ITER)
    ) else $error("iteration counter out of range");

endmodule

`default_nettype wire

// File: source/div_pkg.sv
`default_nettype none

package div_pkg;

    // operand and result width
    localparam int OP_LN = 32;
    // extra fraction bits kept through the iterations, at least 1
    localparam int XP_LN = 4;
    // width of the iteration datapath
    localparam int C_LN = OP_LN + XP_LN;
    // bits of a bit index into an operand
    localparam int OP_LN_LG = 5;
    // five iterations cover 32 bits of quotient
    localparam int NUM_ITER = 5;

    // same order as the low two bits of the M-extension funct3
    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_fn_t;

    // class of an operation, anything but NORMAL completes in one cycle
    typedef enum logic [1:0] {
        NORMAL,
        DIV0,
        OVFL,
        CACHED
    } div_case_t;

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        FINISH
    } div_state_t;

endpackage

`default_nettype wire
